// ==== Makefile ====
SIM      = verilator
TOP      = tb_equalizer
FILELIST = list.f
FLAGS    = --binary --assert --timing -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== conj_product.sv ====
`default_nettype none

module conj_product
    import ofdm_pkg::*, eq_types_pkg::*;
#(
    parameter int scale_shift    = 6,
    parameter int dividend_width = 32,
    parameter int divisor_width  = 24
) (
    input  logic     clock,
    input  logic     reset,
    sym_if.dst       sym,
    div_lane_if.feed lanes [num_lanes]
);

    localparam int prod_width = 2 * iq_width;

    // partial products of y * conj(h) and |h|^2
    logic signed [prod_width-1:0]     p_ii;
    logic signed [prod_width-1:0]     p_qq;
    logic signed [prod_width-1:0]     p_qi;
    logic signed [prod_width-1:0]     p_iq;
    logic [prod_width-1:0]            m_ii;
    logic [prod_width-1:0]            m_qq;
    logic                             s1_valid;

    logic signed [prod_width:0]       sum_re;
    logic signed [prod_width:0]       sum_im;
    logic [prod_width:0]              mag_sum;

    logic signed [dividend_width-1:0] num_q [num_lanes];
    logic [divisor_width-1:0]         den_q;
    logic                             s2_valid;

    sc_idx_t                          next_idx;

    always_ff @(posedge clock) begin
        p_ii <= sym.sample.iq.i * sym.est.iq.i;
        p_qq <= sym.sample.iq.q * sym.est.iq.q;
        p_qi <= sym.sample.iq.q * sym.est.iq.i;
        p_iq <= sym.sample.iq.i * sym.est.iq.q;
        m_ii <= sym.est.iq.i * sym.est.iq.i;
        m_qq <= sym.est.iq.q * sym.est.iq.q;
    end

    assign sum_re  = p_ii + p_qq;
    assign sum_im  = p_qi - p_iq;
    assign mag_sum = m_ii + m_qq;

    // extra bit of scaling keeps the constellation above the slicer threshold
    always_ff @(posedge clock) begin
        num_q[lane_i] <= dividend_width'(sum_re) <<< (scale_shift + 1);
        num_q[lane_q] <= dividend_width'(sum_im) <<< (scale_shift + 1);
        den_q         <= divisor_width'(mag_sum);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            next_idx <= '0;
        end else begin
            s1_valid <= sym.valid;
            s2_valid <= s1_valid;
            if (sym.valid) begin
                next_idx <= sym.idx + 1'b1;
            end
        end
    end

    for (genvar g = 0; g < num_lanes; g++) begin : g_feed
        assign lanes[g].dividend = num_q[g];
        assign lanes[g].divisor  = den_q;
        assign lanes[g].in_valid = s2_valid;
    end

    // the selector counts subcarriers on its own, so the stream must stay in order
    assert property (@(posedge clock) disable iff (reset)
        sym.valid |-> (sym.idx == next_idx))
        else $error("symbol stream index %0d, expected %0d", sym.idx, next_idx);

endmodule

`default_nettype wire

// ==== eq_ifs.sv ====
`default_nettype none

// one subcarrier per valid pulse, no ready
interface sym_if
    import ofdm_pkg::*, eq_types_pkg::*;
();
    sample_word_u sample;
    sample_word_u est;
    sc_idx_t      idx;
    logic         valid;

    modport src (output sample, est, idx, valid);
    modport dst (input sample, est, idx, valid);
endinterface

// one divider lane, the quotient follows in_valid by dividend_width cycles
interface div_lane_if #(
    parameter int dividend_width = 32,
    parameter int divisor_width  = 24
) ();
    logic signed [dividend_width-1:0] dividend;
    logic [divisor_width-1:0]         divisor;
    logic                             in_valid;
    logic signed [dividend_width-1:0] quotient;
    logic                             out_valid;

    modport feed  (output dividend, divisor, in_valid);
    modport lane  (input dividend, divisor, in_valid, output quotient, out_valid);
    modport drain (input quotient, out_valid);
endinterface

`default_nettype wire

// ==== eq_types_pkg.sv ====
`default_nettype none

package eq_types_pkg;

    localparam int iq_width     = 16;
    localparam int sample_width = 2 * iq_width;

    // I in the upper half, Q in the lower half
    typedef struct packed {
        logic signed [iq_width-1:0] i;
        logic signed [iq_width-1:0] q;
    } iq_t;

    // raw view for storage and transport, iq view for arithmetic
    typedef union packed {
        logic [sample_width-1:0] raw;
        iq_t                     iq;
    } sample_word_u;

    // one divider lane per component
    localparam int num_lanes = 2;
    localparam int lane_i    = 0;
    localparam int lane_q    = 1;

    typedef enum logic [1:0] {
        first_lts,
        second_lts,
        data_symbols
    } est_phase_t;

endpackage

`default_nettype wire

// ==== equalizer_top.sv ====
`default_nettype none

module equalizer_top
    import eq_types_pkg::*;
#(
    parameter int scale_shift    = 6,
    parameter int dividend_width = 32,
    parameter int divisor_width  = 24
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [sample_width-1:0] sample_i,
    input  logic                    sample_stb_i,
    output logic [sample_width-1:0] sample_o,
    output logic                    sample_stb_o
);

    sample_word_u in_word;

    sym_if sym ();

    div_lane_if #(
        .dividend_width(dividend_width),
        .divisor_width (divisor_width)
    ) lanes [num_lanes] ();

    assign in_word.raw = sample_i;

    lts_estimator u_est (
        .clock       (clock),
        .reset       (reset),
        .sample_i    (in_word),
        .sample_stb_i(sample_stb_i),
        .sym         (sym)
    );

    conj_product #(
        .scale_shift   (scale_shift),
        .dividend_width(dividend_width),
        .divisor_width (divisor_width)
    ) u_conj (
        .clock(clock),
        .reset(reset),
        .sym  (sym),
        .lanes(lanes)
    );

    // lane 0 divides I, lane 1 divides Q
    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        pipelined_divider #(
            .dividend_width(dividend_width),
            .divisor_width (divisor_width)
        ) u_div (
            .clock(clock),
            .reset(reset),
            .lane (lanes[g])
        );
    end

    subcarrier_select u_sel (
        .clock       (clock),
        .reset       (reset),
        .lanes       (lanes),
        .sample_o    (sample_o),
        .sample_stb_o(sample_stb_o)
    );

endmodule

`default_nettype wire

// ==== list.f ====
ofdm_pkg.sv
eq_types_pkg.sv
eq_ifs.sv
lts_estimator.sv
conj_product.sv
pipelined_divider.sv
subcarrier_select.sv
equalizer_top.sv
tb_equalizer.sv

// ==== lts_estimator.sv ====
`default_nettype none

module lts_estimator
    import ofdm_pkg::*, eq_types_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  sample_word_u sample_i,
    input  logic         sample_stb_i,
    sym_if.src           sym
);

    localparam sc_idx_t last_idx = sc_idx_t'(fft_len - 1);

    // channel estimate per subcarrier
    logic [sample_width-1:0] chan_mem [fft_len];

    est_phase_t   phase;
    sc_idx_t      idx;
    logic         rd_en;
    logic         wr_en;

    // read stage
    logic         s1_stb;
    est_phase_t   s1_phase;
    sc_idx_t      s1_idx;
    sample_word_u s1_sample;
    sample_word_u s1_chan;

    sample_word_u avg;
    sample_word_u wr_word;

    // mean of the two LTS values, sign flipped where the reference is -1
    function automatic logic signed [iq_width-1:0] half_sum(
        input logic signed [iq_width-1:0] a,
        input logic signed [iq_width-1:0] b,
        input logic                       neg
    );
        logic signed [iq_width:0]   sum;
        logic signed [iq_width-1:0] half;
        sum  = a + b;
        half = sum[iq_width:1];
        return neg ? -half : half;
    endfunction

    assign rd_en = sample_stb_i && (phase != first_lts);
    assign wr_en = s1_stb && (s1_phase != data_symbols);

    always_comb begin
        avg.iq.i = half_sum(s1_sample.iq.i, s1_chan.iq.i, lts_ref[s1_idx]);
        avg.iq.q = half_sum(s1_sample.iq.q, s1_chan.iq.q, lts_ref[s1_idx]);
        // LTS1 goes in as received
        wr_word  = (s1_phase == first_lts) ? s1_sample : avg;
    end

    always_ff @(posedge clock) begin
        if (rd_en) begin
            s1_chan.raw <= chan_mem[idx];
        end
        if (wr_en) begin
            chan_mem[s1_idx] <= wr_word.raw;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phase     <= first_lts;
            idx       <= '0;
            s1_stb    <= 1'b0;
            sym.valid <= 1'b0;
        end else begin
            s1_stb    <= sample_stb_i;
            sym.valid <= s1_stb && (s1_phase == data_symbols);
            if (sample_stb_i) begin
                idx <= idx + 1'b1;
                if (idx == last_idx) begin
                    if (phase == first_lts) begin
                        phase <= second_lts;
                    end else begin
                        // the estimate then holds until the next reset
                        phase <= data_symbols;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        s1_phase   <= phase;
        s1_idx     <= idx;
        s1_sample  <= sample_i;
        sym.sample <= s1_sample;
        sym.est    <= s1_chan;
        sym.idx    <= s1_idx;
    end

    // averaging write for k lands while k+1 is read on back-to-back strobes
    assert property (@(posedge clock) disable iff (reset)
        (rd_en && wr_en) |-> (idx != s1_idx))
        else $error("channel memory read and write collide at index %0d", idx);

endmodule

`default_nettype wire

// ==== ofdm_pkg.sv ====
`default_nettype none

package ofdm_pkg;

    // one legacy OFDM symbol on a 64-point FFT
    localparam int fft_len = 64;

    typedef logic [$clog2(fft_len)-1:0] sc_idx_t;

    // all masks share one bit order
    // bit 0 is DC and bits 1 to 26 are subcarriers 1 to 26
    // bits 38 to 63 are subcarriers -26 to -1
    localparam logic [fft_len-1:0] sc_mask =
        64'b1111111111111111111111111100000000000111111111111111111111111110;

    // pilots sit at -7, -21, 21 and 7
    localparam logic [fft_len-1:0] pilot_mask =
        64'b0000001000000000000010000000000000000000001000000000000010000000;

    // occupied carriers without the four pilots
    localparam logic [fft_len-1:0] data_sc_mask = sc_mask & ~pilot_mask;

    // a set bit marks a subcarrier where the LTS symbol is -1
    localparam logic [fft_len-1:0] lts_ref =
        64'b0000101001100000010100110000000000000000010101100111110101001100;

    // equalized outputs per data symbol
    localparam int num_data_sc = 48;

endpackage

`default_nettype wire

// ==== pipelined_divider.sv ====
`default_nettype none

module pipelined_divider #(
    parameter int dividend_width = 32,
    parameter int divisor_width  = 24
) (
    input  logic     clock,
    input  logic     reset,
    div_lane_if.lane lane
);

    localparam int last_stage = dividend_width - 1;

    logic                      in_neg;
    logic [dividend_width-1:0] in_mag;

    // divide magnitudes, sign comes back at the end
    assign in_neg = lane.dividend[dividend_width-1];
    assign in_mag = in_neg ? -lane.dividend : lane.dividend;

    // one restoring step per quotient bit, MSB first
    for (genvar s = 0; s < dividend_width; s++) begin : g_stage
        logic [divisor_width-1:0]  rem_in;
        logic [dividend_width-1:0] acc_in;
        logic [divisor_width-1:0]  dsr_in;
        logic                      neg_in;
        logic                      vld_in;
        logic [divisor_width:0]    trial;
        logic                      fits;

        logic [divisor_width-1:0]  rem_q;
        logic [dividend_width-1:0] acc_q;
        logic [divisor_width-1:0]  dsr_q;
        logic                      neg_q;
        logic                      vld_q;

        if (s == 0) begin : g_head
            assign rem_in = '0;
            assign acc_in = in_mag;
            assign dsr_in = lane.divisor;
            assign neg_in = in_neg;
            assign vld_in = lane.in_valid;
        end else begin : g_tail
            assign rem_in = g_stage[s-1].rem_q;
            assign acc_in = g_stage[s-1].acc_q;
            assign dsr_in = g_stage[s-1].dsr_q;
            assign neg_in = g_stage[s-1].neg_q;
            assign vld_in = g_stage[s-1].vld_q;
        end

        // bring down the next dividend bit
        assign trial = {rem_in, acc_in[dividend_width-1]};
        assign fits  = (trial >= {1'b0, dsr_in});

        always_ff @(posedge clock) begin
            if (reset) begin
                vld_q <= 1'b0;
            end else begin
                vld_q <= vld_in;
            end
        end

        // quotient bits fill acc from the bottom as dividend bits leave the top
        always_ff @(posedge clock) begin
            rem_q <= fits ? divisor_width'(trial - {1'b0, dsr_in})
                          : trial[divisor_width-1:0];
            acc_q <= {acc_in[dividend_width-2:0], fits};
            dsr_q <= dsr_in;
            neg_q <= neg_in;
        end
    end

    // truncates toward zero
    assign lane.quotient  = g_stage[last_stage].neg_q ? -g_stage[last_stage].acc_q
                                                      : g_stage[last_stage].acc_q;
    assign lane.out_valid = g_stage[last_stage].vld_q;

    assert property (@(posedge clock) disable iff (reset)
        lane.in_valid |-> (lane.divisor != '0))
        else $error("divider lane started with a zero divisor");

endmodule

`default_nettype wire

// ==== subcarrier_select.sv ====
`default_nettype none

module subcarrier_select
    import ofdm_pkg::*, eq_types_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    div_lane_if.drain               lanes [num_lanes],
    output logic [sample_width-1:0] sample_o,
    output logic                    sample_stb_o
);

    sc_idx_t             sc_cnt;
    logic                lane_valid;
    logic [iq_width-1:0] half_word [num_lanes];

    assign lane_valid = lanes[lane_i].out_valid;

    // sign bit followed by the low 15 bits of each quotient
    for (genvar g = 0; g < num_lanes; g++) begin : g_pack
        assign half_word[g] = {lanes[g].quotient < 0, lanes[g].quotient[iq_width-2:0]};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            sc_cnt       <= '0;
            sample_stb_o <= 1'b0;
        end else begin
            // pilots, DC and guard carriers are dropped here
            sample_stb_o <= lane_valid && data_sc_mask[sc_cnt];
            if (lane_valid) begin
                sc_cnt <= sc_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (lane_valid) begin
            sample_o <= {half_word[lane_i], half_word[lane_q]};
        end
    end

    // both lanes get the same strobe and the same latency
    assert property (@(posedge clock) disable iff (reset)
        lanes[lane_i].out_valid == lanes[lane_q].out_valid)
        else $error("divider lanes out of step");

endmodule

`default_nettype wire

// ==== tb_equalizer.sv ====
`default_nettype none

module tb_equalizer
    import ofdm_pkg::*, eq_types_pkg::*;
;

    localparam int scale_shift = 6;
    localparam logic [15:0] unity = 16'(1 << (scale_shift + 1));

    logic        clock;
    logic        reset;
    logic [31:0] sample_i;
    logic        sample_stb_i;
    logic [31:0] sample_o;
    logic        sample_stb_o;

    int          seed = 32'hd43b_029e;
    logic [31:0] exp_q [$];
    string       test_name;
    int          mismatch_errors;
    int          other_errors;
    int          out_count;
    bit          training;
    bit          reset_prev = 1'b1;

    // reference channel estimate and stored data symbols
    int          est_i [fft_len];
    int          est_q [fft_len];
    logic [31:0] data_mem [4][fft_len];

    equalizer_top #(
        .scale_shift   (scale_shift),
        .dividend_width(32),
        .divisor_width (24)
    ) dut0 (
        .clock       (clock),
        .reset       (reset),
        .sample_i    (sample_i),
        .sample_stb_i(sample_stb_i),
        .sample_o    (sample_o),
        .sample_stb_o(sample_stb_o)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] iq_word(input int i, input int q);
        return {i[15:0], q[15:0]};
    endfunction

    // sign bit, then the low 15 bits of the quotient
    function automatic logic [15:0] pack_lane(input longint q);
        return {q < 0, q[14:0]};
    endfunction

    // y * conj(h), scaled, divided by |h|^2 with truncation toward zero
    function automatic logic [31:0] equalized(input int yi, input int yq, input int hi,
                                              input int hq);
        longint re;
        longint im;
        longint mag;
        longint scale;
        re    = longint'(yi) * hi + longint'(yq) * hq;
        im    = longint'(yq) * hi - longint'(yi) * hq;
        mag   = longint'(hi) * hi + longint'(hq) * hq;
        scale = longint'(1) << (scale_shift + 1);
        return {pack_lane((re * scale) / mag), pack_lane((im * scale) / mag)};
    endfunction

    // an output is legal only after reset, outside training, and in queue order
    always @(posedge clock) begin : check_output
        logic [31:0] exp_word;
        if (sample_stb_o === 1'b1) begin
            assert (!reset_prev) else begin
                other_errors++;
                $display("output strobe while reset was applied");
            end
            if (!reset_prev && !reset) begin
                assert (!training) else begin
                    other_errors++;
                    $display("output strobe during the training symbols of %s", test_name);
                end
                assert (exp_q.size() > 0) else begin
                    other_errors++;
                    $display("output strobe with no expected sample in %s", test_name);
                end
                if (exp_q.size() > 0) begin
                    exp_word = exp_q.pop_front();
                    out_count++;
                    assert (sample_o == exp_word) else begin
                        mismatch_errors++;
                        $display("mismatch %s: expected %h, actual %h",
                                 test_name, exp_word, sample_o);
                    end
                end
            end
        end
        reset_prev = reset;
    end

    task automatic finish_sim();
        $display("error counts: %0d mismatches, %0d other errors",
                 mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        out_count = 0;
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset        = 1'b1;
        sample_stb_i = 1'b0;
        training     = 1'b1;
        exp_q.delete();
        repeat (16) @(negedge clock);
        reset = 1'b0;
    endtask

    // one strobe, then an optional random gap
    task automatic drive_word(input logic [31:0] w, input bit gaps);
        int r;
        int n;
        n = 0;
        if (gaps) begin
            r = $random(seed);
            n = r & 3;
        end
        @(negedge clock);
        sample_i     = w;
        sample_stb_i = 1'b1;
        repeat (n) begin
            @(negedge clock);
            sample_stb_i = 1'b0;
        end
    endtask

    task automatic end_burst();
        @(negedge clock);
        sample_stb_i = 1'b0;
    endtask

    // LTS2 stays within a few counts of LTS1 so the estimate is never zero
    task automatic load_channel(input bit gaps);
        int r;
        int l1_i [fft_len];
        int l1_q [fft_len];
        int l2_i;
        int l2_q;
        int sum_i;
        int sum_q;
        for (int k = 0; k < fft_len; k++) begin
            r       = $random(seed);
            l1_i[k] = (8 + (r & 31)) * (r[8] ? -1 : 1);
            l1_q[k] = (8 + ((r >>> 12) & 31)) * (r[20] ? -1 : 1);
            drive_word(iq_word(l1_i[k], l1_q[k]), gaps);
        end
        for (int k = 0; k < fft_len; k++) begin
            r     = $random(seed);
            l2_i  = l1_i[k] + (r & 3) - 2;
            l2_q  = l1_q[k] + ((r >>> 4) & 3) - 2;
            drive_word(iq_word(l2_i, l2_q), gaps);
            sum_i = l1_i[k] + l2_i;
            sum_q = l1_q[k] + l2_q;
            est_i[k] = lts_ref[k] ? -(sum_i >>> 1) : (sum_i >>> 1);
            est_q[k] = lts_ref[k] ? -(sum_q >>> 1) : (sum_q >>> 1);
        end
    endtask

    task automatic make_data(input int s);
        int r;
        for (int k = 0; k < fft_len; k++) begin
            r = $random(seed);
            data_mem[s][k] = iq_word((r & 2047) - 1024, ((r >>> 16) & 2047) - 1024);
        end
    endtask

    // identity symbols carry the estimate itself as data
    task automatic drive_symbol(input int s, input bit identity, input bit gaps,
                                input int count);
        logic [31:0] w;
        int          yi;
        int          yq;
        for (int k = 0; k < count; k++) begin
            w  = identity ? iq_word(est_i[k], est_q[k]) : data_mem[s][k];
            yi = int'($signed(w[31:16]));
            yq = int'($signed(w[15:0]));
            if (data_sc_mask[k]) begin
                if (identity) begin
                    exp_q.push_back({unity, 16'h0000});
                end else begin
                    exp_q.push_back(equalized(yi, yq, est_i[k], est_q[k]));
                end
            end
            training = 1'b0;
            drive_word(w, gaps);
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() > 0 && t < 1000) begin
            @(negedge clock);
            t++;
        end
        if (exp_q.size() > 0) begin
            other_errors++;
            $display("timeout: %0d expected outputs never arrived in %s",
                     exp_q.size(), test_name);
            exp_q.delete();
        end
        // room for any stray strobe to show up
        repeat (64) @(negedge clock);
    endtask

    task automatic check_count(input int nsym);
        assert (out_count == num_data_sc * nsym) else begin
            mismatch_errors++;
            $display("mismatch %s output count: expected %0d, actual %0d",
                     test_name, num_data_sc * nsym, out_count);
        end
    endtask

    initial begin
        reset           = 1'b1;
        sample_i        = '0;
        sample_stb_i    = 1'b0;
        training        = 1'b1;
        mismatch_errors = 0;
        other_errors    = 0;
        out_count       = 0;
        test_name       = "reset";
        apply_reset();

        start_test("identity");
        load_channel(1'b0);
        for (int s = 0; s < 3; s++) begin
            drive_symbol(0, 1'b1, 1'b0, fft_len);
        end
        end_burst();
        wait_drain();
        check_count(3);

        apply_reset();
        start_test("random");
        load_channel(1'b1);
        for (int s = 0; s < 4; s++) begin
            make_data(s);
        end
        for (int s = 0; s < 4; s++) begin
            drive_symbol(s, 1'b0, 1'b0, fft_len);
        end
        end_burst();
        wait_drain();
        check_count(4);

        // same symbols and estimate, now with gaps
        start_test("gaps");
        for (int s = 0; s < 4; s++) begin
            drive_symbol(s, 1'b0, 1'b1, fft_len);
        end
        end_burst();
        wait_drain();
        check_count(4);

        start_test("reset_mid_old");
        make_data(0);
        make_data(1);
        drive_symbol(0, 1'b0, 1'b1, fft_len);
        drive_symbol(1, 1'b0, 1'b0, 30);
        apply_reset();
        start_test("reset_mid_new");
        load_channel(1'b0);
        make_data(0);
        make_data(1);
        drive_symbol(0, 1'b0, 1'b1, fft_len);
        drive_symbol(1, 1'b0, 1'b0, fft_len);
        end_burst();
        wait_drain();
        check_count(2);

        finish_sim();
    end

endmodule

`default_nettype wire
